// File: hw/notchPkg.sv
// Notch filter shared definitions
package notchPkg;

	typedef logic signed [31:0] sampleT;	// one memory word
	typedef logic signed [15:0] coeffT;	// scaled by 2^14
	typedef logic signed [63:0] accT;	// products, sums, y history
	typedef logic [23:0] addrT;	// byte address
	typedef logic [23:0] countT;	// sample count

	localparam int COEFF_SHIFT = 14;	// divide by 16384
	localparam int ADDR_STEP = 4;	// bytes per sample
	localparam int FIFO_DEPTH = 16;

	// notch around the design frequency
	localparam coeffT COEF_A1 = -16'sd31035;
	localparam coeffT COEF_A2 = 16'sd14969;
	localparam coeffT COEF_B0 = 16'sd8275;
	localparam coeffT COEF_B1 = -16'sd16383;
	localparam coeffT COEF_B2 = 16'sd8275;

	localparam logic [31:0] ACCEPT_CODE = 32'd99;	// start taken
	localparam logic [31:0] BUSY_CODE = '1;	// start refused

	// dataa[1:0] of a command
	typedef enum logic [1:0] {
		opStatus = 2'd0,
		opSetCount = 2'd1,
		opStart = 2'd2,
		opProgress = 2'd3
	} opcodeE;

	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stRun = 2'd1,
		stIrqWait = 2'd2	// run done, irq pending
	} runStateE;

	// master side of the memory port
	typedef struct packed {
		logic read;
		logic write;
		addrT address;
		sampleT writedata;
	} memReqT;

	// slave side of the memory port
	typedef struct packed {
		sampleT readdata;
		logic readdatavalid;
		logic waitrequest;
	} memRspT;

	// run request from control to streamer
	typedef struct packed {
		logic go;	// one cycle
		addrT base;
		countT count;
	} runCmdT;

endpackage

// File: hw/sampleFifo.sv
// Sample FIFO with fall-through output
`timescale 1ns/10ps

module sampleFifo (
	input logic clk,
	input logic rst,
	input logic clear,	// synchronous purge
	input logic push,
	input notchPkg::sampleT pushData,
	input logic pop,
	output notchPkg::sampleT popData,
	output logic valid,
	output logic full,
	output logic [4:0] used
);

	notchPkg::sampleT mem [notchPkg::FIFO_DEPTH];
	logic [$clog2(notchPkg::FIFO_DEPTH)-1:0] wrPtr;
	logic [$clog2(notchPkg::FIFO_DEPTH)-1:0] rdPtr;
	logic doPush;
	logic doPop;

	assign full = (used == 5'(notchPkg::FIFO_DEPTH));
	assign valid = (used != '0);
	assign doPush = push && !full;	// drop on overflow
	assign doPop = pop && valid;
	assign popData = mem[rdPtr];	// head always visible

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			wrPtr <= '0;
			rdPtr <= '0;
			used <= '0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop) rdPtr <= rdPtr + 1'b1;
			used <= used + 5'(doPush) - 5'(doPop);
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushData;
	end

endmodule

// File: hw/notchControl.sv
// Command decode and run control
`timescale 1ns/10ps

module notchControl (
	input logic clk,
	input logic rst,
	input logic start,	// one-cycle command strobe
	input logic [31:0] dataa,
	input logic [31:0] datab,
	output logic done,
	output logic [31:0] result,
	output logic irq,
	output notchPkg::runCmdT runCmd,
	input notchPkg::countT writtenCount,
	input logic finished
);

	notchPkg::runStateE state;
	notchPkg::countT sampleCount;	// from setCount
	notchPkg::opcodeE opcode;

	assign opcode = notchPkg::opcodeE'(dataa[1:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= notchPkg::stIdle;
			done <= 1'b0;
			irq <= 1'b0;
			runCmd.go <= 1'b0;
			sampleCount <= '0;
		end else begin
			done <= start;	// answer one cycle later
			runCmd.go <= 1'b0;	// pulse only

			if (start) begin
				case (opcode)
					notchPkg::opStatus: begin
						result <= 32'(state);
						if (state == notchPkg::stIrqWait) begin	// query services irq
							irq <= 1'b0;
							state <= notchPkg::stIdle;
						end
					end
					notchPkg::opSetCount: begin
						sampleCount <= datab[23:0];
						result <= datab;	// echo
					end
					notchPkg::opStart: begin
						if (state == notchPkg::stIdle) begin
							runCmd.go <= 1'b1;
							runCmd.base <= datab[23:0];
							runCmd.count <= sampleCount;
							state <= notchPkg::stRun;
							result <= notchPkg::ACCEPT_CODE;
						end else begin
							result <= notchPkg::BUSY_CODE;	// run in progress, ignore
						end
					end
					notchPkg::opProgress: begin
						result <= 32'(writtenCount);	// samples written back
					end
				endcase
			end

			// streamer reports last write accepted
			if (finished && state == notchPkg::stRun) begin
				state <= notchPkg::stIrqWait;
				irq <= 1'b1;
			end
		end
	end

endmodule

// File: hw/memStreamer.sv
// Memory read and write-back streamer
`timescale 1ns/10ps

module memStreamer (
	input logic clk,
	input logic rst,
	input notchPkg::runCmdT runCmd,
	output notchPkg::memReqT memReq,
	input notchPkg::memRspT memRsp,
	output logic rdPush,
	output notchPkg::sampleT rdData,
	input logic [4:0] rdCount,	// read fifo occupancy
	input notchPkg::sampleT wrData,
	input logic wrValid,
	output logic wrPop,
	output notchPkg::countT writtenCount,
	output logic finished
);

	logic active;	// run in progress
	notchPkg::addrT rdAddr;	// next read address
	notchPkg::addrT wrAddr;	// next write address
	notchPkg::countT issued;	// reads launched
	notchPkg::countT total;
	logic [4:0] inFlight;	// reads launched, data not yet back

	logic writeAccept;
	logic reqHeld;
	logic creditOk;
	logic canRead;
	notchPkg::countT writtenNext;
	logic lastWrite;

	// returned data goes straight into the read fifo
	assign rdPush = memRsp.readdatavalid;
	assign rdData = memRsp.readdata;

	assign writeAccept = memReq.write && !memRsp.waitrequest;
	assign reqHeld = (memReq.read || memReq.write) && memRsp.waitrequest;

	// in-flight reads plus buffered words never exceed the fifo
	assign creditOk = ({1'b0, inFlight} + {1'b0, rdCount}) < 6'(notchPkg::FIFO_DEPTH);
	assign canRead = active && !reqHeld && (issued < total) && creditOk;

	// write-back only in slots not taken by a read
	assign wrPop = active && !reqHeld && !canRead && wrValid;

	assign writtenNext = writtenCount + notchPkg::countT'(writeAccept);
	assign lastWrite = active && (writtenNext == total);

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			memReq.read <= 1'b0;
			memReq.write <= 1'b0;
			finished <= 1'b0;
			issued <= '0;
			writtenCount <= '0;
			inFlight <= '0;
		end else if (runCmd.go) begin
			active <= 1'b1;
			rdAddr <= runCmd.base;	// in-place, both start at base
			wrAddr <= runCmd.base;
			total <= runCmd.count;
			issued <= '0;
			writtenCount <= '0;
			inFlight <= '0;
			finished <= 1'b0;
			memReq.read <= 1'b0;
			memReq.write <= 1'b0;
		end else begin
			finished <= lastWrite;	// cycle after last accept
			if (lastWrite) active <= 1'b0;
			writtenCount <= writtenNext;
			inFlight <= inFlight + 5'(canRead) - 5'(memRsp.readdatavalid);

			// request held until waitrequest drops
			if (!reqHeld) begin
				memReq.read <= canRead;
				memReq.write <= wrPop;
				if (canRead) begin
					memReq.address <= rdAddr;
					rdAddr <= rdAddr + notchPkg::addrT'(notchPkg::ADDR_STEP);
					issued <= issued + 1'b1;
				end else if (wrPop) begin
					memReq.address <= wrAddr;
					memReq.writedata <= wrData;
					wrAddr <= wrAddr + notchPkg::addrT'(notchPkg::ADDR_STEP);
				end
			end
		end
	end

endmodule

// File: hw/biquadCore.sv
// Staged biquad filter core
`timescale 1ns/10ps

module biquadCore (
	input logic clk,
	input logic rst,
	input logic clearHistory,	// start of a run
	input notchPkg::sampleT inData,
	input logic inValid,
	output logic inPop,
	output notchPkg::sampleT outData,
	output logic outPush,
	input logic outFull
);

	typedef enum logic [2:0] {
		csFetch,
		csShift,
		csProduct,
		csSumPart,
		csSumAll,
		csScale,
		csOutput
	} coreStageE;

	coreStageE stage;

	notchPkg::sampleT xIn;	// fetched sample
	notchPkg::sampleT x0;	// x[n]
	notchPkg::sampleT x1;	// x[n-1]
	notchPkg::sampleT x2;	// x[n-2]
	notchPkg::accT y1;	// y[n-1], full width
	notchPkg::accT y2;	// y[n-2]

	notchPkg::accT pB0;
	notchPkg::accT pB1;
	notchPkg::accT pB2;
	notchPkg::accT pA1;
	notchPkg::accT pA2;
	notchPkg::accT sumB;	// feedforward part
	notchPkg::accT sumA;	// feedback part
	notchPkg::accT acc;
	notchPkg::accT scaled;

	assign inPop = (stage == csFetch) && inValid;	// fall-through head taken now

	always_ff @(posedge clk) begin
		if (rst || clearHistory) begin
			stage <= csFetch;
			outPush <= 1'b0;
			x0 <= '0;
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end else begin
			outPush <= 1'b0;
			case (stage)
				csFetch: begin
					if (inValid) begin
						xIn <= inData;
						stage <= csShift;
					end
				end
				csShift: begin
					x0 <= xIn;
					x1 <= x0;
					x2 <= x1;
					stage <= csProduct;
				end
				csProduct: begin	// all five products at once
					pB0 <= notchPkg::accT'(x0) * notchPkg::accT'(notchPkg::COEF_B0);
					pB1 <= notchPkg::accT'(x1) * notchPkg::accT'(notchPkg::COEF_B1);
					pB2 <= notchPkg::accT'(x2) * notchPkg::accT'(notchPkg::COEF_B2);
					pA1 <= y1 * notchPkg::accT'(notchPkg::COEF_A1);
					pA2 <= y2 * notchPkg::accT'(notchPkg::COEF_A2);
					stage <= csSumPart;
				end
				csSumPart: begin
					sumB <= pB0 + pB1 + pB2;
					sumA <= pA1 + pA2;
					stage <= csSumAll;
				end
				csSumAll: begin
					acc <= sumB - sumA;
					stage <= csScale;
				end
				csScale: begin
					scaled <= acc >>> notchPkg::COEFF_SHIFT;	// arithmetic, keeps sign
					stage <= csOutput;
				end
				csOutput: begin
					if (!outFull) begin	// stall on full write fifo
						outData <= scaled[31:0];
						outPush <= 1'b1;
						y1 <= scaled;
						y2 <= y1;
						stage <= csFetch;
					end
				end
				default: begin
					stage <= csFetch;
				end
			endcase
		end
	end

endmodule

// File: hw/notchTop.sv
// Notch filter accelerator top
`timescale 1ns/10ps

module notchTop (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [31:0] dataa,
	input logic [31:0] datab,
	output logic done,
	output logic [31:0] result,
	output logic irq,
	output notchPkg::memReqT memReq,
	input notchPkg::memRspT memRsp
);

	notchPkg::runCmdT runCmd;
	notchPkg::countT writtenCount;
	logic finished;

	logic rdPush;	// memory return into read fifo
	notchPkg::sampleT rdData;
	logic [4:0] rdUsed;
	notchPkg::sampleT rdPopData;
	logic rdValid;
	logic rdPop;

	notchPkg::sampleT wrPushData;	// core result into write fifo
	logic wrPush;
	logic wrFull;
	notchPkg::sampleT wrPopData;
	logic wrValid;
	logic wrPop;

	notchControl control (
		.clk(clk), .rst(rst),
		.start(start), .dataa(dataa), .datab(datab),
		.done(done), .result(result), .irq(irq),
		.runCmd(runCmd), .writtenCount(writtenCount), .finished(finished)
	);

	memStreamer streamer (
		.clk(clk), .rst(rst),
		.runCmd(runCmd),
		.memReq(memReq), .memRsp(memRsp),
		.rdPush(rdPush), .rdData(rdData), .rdCount(rdUsed),
		.wrData(wrPopData), .wrValid(wrValid), .wrPop(wrPop),
		.writtenCount(writtenCount), .finished(finished)
	);

	sampleFifo readFifo (
		.clk(clk), .rst(rst), .clear(runCmd.go),	// purge on each start
		.push(rdPush), .pushData(rdData),
		.pop(rdPop), .popData(rdPopData),
		.valid(rdValid), .full(), .used(rdUsed)
	);

	biquadCore core (
		.clk(clk), .rst(rst), .clearHistory(runCmd.go),
		.inData(rdPopData), .inValid(rdValid), .inPop(rdPop),
		.outData(wrPushData), .outPush(wrPush), .outFull(wrFull)
	);

	sampleFifo writeFifo (
		.clk(clk), .rst(rst), .clear(runCmd.go),
		.push(wrPush), .pushData(wrPushData),
		.pop(wrPop), .popData(wrPopData),
		.valid(wrValid), .full(wrFull), .used()
	);

endmodule

// File: tests/notchMemModel.sv
// Behavioral memory slave
`timescale 1ns/10ps

module notchMemModel (
	input logic clk,
	input logic rst,
	input int waitPercent,	// chance of waitrequest per cycle
	input logic loadEn,	// preload port
	input logic [8:0] loadIndex,
	input notchPkg::sampleT loadData,
	input notchPkg::memReqT memReq,
	output notchPkg::memRspT memRsp
);

	notchPkg::sampleT words [512];	// word addressed
	notchPkg::sampleT rdQueue [$];	// read data in issue order
	int dueQueue [$];	// return cycle per read
	int cycle;
	int lastDue;
	int lat;
	integer seed = 26;
	logic [8:0] index;

	assign index = memReq.address[10:2];

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 512; i++) begin
				words[i] <= {8'hC3, 24'(i * 4)};	// tagged with its own byte address
			end
			memRsp.waitrequest <= 1'b0;
			memRsp.readdatavalid <= 1'b0;
			rdQueue.delete();
			dueQueue.delete();
			cycle = 0;
			lastDue = 0;
		end else begin
			cycle = cycle + 1;
			if (loadEn) words[loadIndex] <= loadData;
			if (memReq.write && !memRsp.waitrequest) words[index] <= memReq.writedata;
			if (memReq.read && !memRsp.waitrequest) begin
				lat = 1 + int'($unsigned($random(seed)) % 32'd4);	// 1 to 4 cycles
				lastDue = (cycle + lat > lastDue) ? cycle + lat : lastDue + 1;	// keep order
				rdQueue.push_back(words[index]);
				dueQueue.push_back(lastDue);
			end
			memRsp.readdatavalid <= 1'b0;
			if (dueQueue.size() > 0 && dueQueue[0] <= cycle) begin
				memRsp.readdata <= rdQueue.pop_front();
				memRsp.readdatavalid <= 1'b1;
				void'(dueQueue.pop_front());
			end
			memRsp.waitrequest <= (int'($unsigned($random(seed)) % 32'd100) < waitPercent);
		end
	end

endmodule

// File: tests/notchTb.sv
// Notch accelerator testbench
`timescale 1ns/10ps

module notchTb;

	localparam int TOTAL_SAMPLES = 65;	// both runs
	localparam int LIMIT_CYCLES = TOTAL_SAMPLES * 200 + 2000;

	logic clk;
	logic rst;
	logic start;
	logic [31:0] dataa;
	logic [31:0] datab;
	logic done;
	logic [31:0] result;
	logic irq;
	notchPkg::memReqT memReq;
	notchPkg::memRspT memRsp;
	int waitPercent;
	logic loadEn;
	logic [8:0] loadIndex;
	notchPkg::sampleT loadData;

	notchPkg::sampleT orig [64];	// inputs of the current run
	notchPkg::sampleT expected [64];
	int runBase;	// word index of first sample
	int runCount;
	int errors;
	int testErrors;	// errors when the test began
	int testsPassed;
	int testsFailed;
	integer seed = 26;
	event checkRun;
	event runChecked;

	notchTop notchTop_i (
		.clk(clk), .rst(rst), .start(start), .dataa(dataa), .datab(datab),
		.done(done), .result(result), .irq(irq), .memReq(memReq), .memRsp(memRsp)
	);

	notchMemModel memory (
		.clk(clk), .rst(rst), .waitPercent(waitPercent),
		.loadEn(loadEn), .loadIndex(loadIndex), .loadData(loadData),
		.memReq(memReq), .memRsp(memRsp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("ERROR: simulation did not finish within %0d cycles", LIMIT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	// direct form I, scaled by 2^14
	function automatic void refBiquad(input int n);
		longint x1 = 0;
		longint x2 = 0;
		longint y1 = 0;
		longint y2 = 0;
		longint acc;
		for (int i = 0; i < n; i++) begin
			acc = longint'(notchPkg::COEF_B0) * longint'(orig[i])
				+ longint'(notchPkg::COEF_B1) * x1 + longint'(notchPkg::COEF_B2) * x2
				- longint'(notchPkg::COEF_A1) * y1 - longint'(notchPkg::COEF_A2) * y2;
			x2 = x1;
			x1 = longint'(orig[i]);
			y2 = y1;
			y1 = acc >>> 14;	// full width kept as history
			expected[i] = notchPkg::sampleT'(y1[31:0]);
		end
	endfunction

	task automatic checkSample(input notchPkg::sampleT got, input notchPkg::sampleT want,
			input string what);
		if (got !== want) begin
			$display("FAILED t=%0t %s: got %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic checkResult(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("FAILED t=%0t %s: got 0x%08h, expected 0x%08h", $time, what, got, want);
			errors++;
		end
	endtask

	// strobe one command, take result one cycle later
	task automatic sendCmd(input notchPkg::opcodeE op, input logic [31:0] arg,
			output logic [31:0] res);
		@(negedge clk);
		start = 1'b1;
		dataa = 32'(op);
		datab = arg;
		@(negedge clk);
		start = 1'b0;
		if (done !== 1'b1) begin
			$display("ERROR: t=%0t done did not follow start by one cycle", $time);
			errors++;
		end
		res = result;
		@(negedge clk);
		if (done !== 1'b0) begin
			$display("ERROR: t=%0t done stayed high longer than one cycle", $time);
			errors++;
		end
	endtask

	task automatic loadRun(input int base, input int count, input logic impulse);
		runBase = base / 4;
		runCount = count;
		for (int i = 0; i < count; i++) begin
			orig[i] = impulse ? ((i == 0) ? 32'sd100000 : 32'sd0) : $random(seed);
			@(negedge clk);
			loadEn = 1'b1;
			loadIndex = 9'(runBase + i);
			loadData = orig[i];
		end
		@(negedge clk);
		loadEn = 1'b0;
		refBiquad(count);
	endtask

	task automatic finishTest(input string name);
		if (errors == testErrors) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors - testErrors);
		end
		testErrors = errors;
	endtask

	// memory after a run, plus guard words around it
	initial begin
		forever begin
			@(checkRun);
			for (int i = 0; i < runCount; i++) begin
				checkSample(memory.words[runBase + i], expected[i], $sformatf("word %0d", i));
			end
			for (int i = runCount; i < runCount + 4; i++) begin
				checkSample(memory.words[runBase + i], {8'hC3, 24'((runBase + i) * 4)},
					"word past the run");
			end
			checkSample(memory.words[runBase - 1], {8'hC3, 24'((runBase - 1) * 4)},
				"word before the run");
			->runChecked;
		end
	end

	initial begin
		logic [31:0] res;
		rst = 1'b1;
		start = 1'b0;
		dataa = '0;
		datab = '0;
		waitPercent = 30;
		loadEn = 1'b0;
		loadIndex = '0;
		loadData = '0;
		errors = 0;
		testErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		checkResult(32'(irq), 32'd0, "irq after reset");
		sendCmd(notchPkg::opStatus, '0, res);
		checkResult(res, 32'(notchPkg::stIdle), "status after reset");
		finishTest("reset state");

		sendCmd(notchPkg::opSetCount, 32'd40, res);
		checkResult(res, 32'd40, "set count echo");
		finishTest("set count");

		loadRun(32'h100, 40, 1'b0);
		sendCmd(notchPkg::opStart, 32'h100, res);
		checkResult(res, notchPkg::ACCEPT_CODE, "start accepted");
		finishTest("start");

		sendCmd(notchPkg::opStart, 32'h200, res);	// still running
		checkResult(res, notchPkg::BUSY_CODE, "start while busy");
		sendCmd(notchPkg::opProgress, '0, res);
		if (res > 32'd40) begin
			$display("FAILED t=%0t progress %0d exceeds the count", $time, res);
			errors++;
		end
		while (irq !== 1'b1) @(negedge clk);	// watchdog bounds this
		sendCmd(notchPkg::opProgress, '0, res);
		checkResult(res, 32'd40, "progress after irq");
		finishTest("busy and progress");

		->checkRun;
		@(runChecked);
		finishTest("first run output");

		sendCmd(notchPkg::opStatus, '0, res);
		checkResult(res, 32'(notchPkg::stIrqWait), "status with irq pending");
		checkResult(32'(irq), 32'd0, "irq after status");
		sendCmd(notchPkg::opStatus, '0, res);
		checkResult(res, 32'(notchPkg::stIdle), "status after irq cleared");
		finishTest("irq clear");

		sendCmd(notchPkg::opSetCount, 32'd25, res);
		checkResult(res, 32'd25, "second count echo");
		loadRun(32'h400, 25, 1'b1);
		waitPercent = 70;	// heavy stalls
		sendCmd(notchPkg::opStart, 32'h400, res);
		checkResult(res, notchPkg::ACCEPT_CODE, "second start accepted");
		while (irq !== 1'b1) @(negedge clk);
		->checkRun;
		@(runChecked);
		sendCmd(notchPkg::opStatus, '0, res);
		checkResult(res, 32'(notchPkg::stIrqWait), "second run status");
		finishTest("impulse run");

		$display("tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: files.f
hw/notchPkg.sv
hw/sampleFifo.sv
hw/notchControl.sv
hw/memStreamer.sv
hw/biquadCore.sv
hw/notchTop.sv
tests/notchMemModel.sv
tests/notchTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module notchTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/VnotchTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
	exit 0
fi
exit 1
